// File: design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
    input  cpuPkg::aluOpT                 i_op,
    input  logic [cpuPkg::DATA_W-1:0]     i_a,
    input  logic [cpuPkg::DATA_W-1:0]     i_b,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_shamt,
    output logic [cpuPkg::DATA_W-1:0]     o_result
);

    logic lessThan;

    // Signed compare for SLT and SLTI
    assign lessThan = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_op)
            cpuPkg::ALU_ADD: o_result = i_a + i_b;
            cpuPkg::ALU_SUB: o_result = i_a - i_b;
            cpuPkg::ALU_AND: o_result = i_a & i_b;
            cpuPkg::ALU_OR:  o_result = i_a | i_b;
            cpuPkg::ALU_XOR: o_result = i_a ^ i_b;
            cpuPkg::ALU_NOR: o_result = ~(i_a | i_b);
            cpuPkg::ALU_SLT: o_result = {{(cpuPkg::DATA_W-1){1'b0}}, lessThan};
            // Shifts move rt by the shamt field
            cpuPkg::ALU_SLL: o_result = i_b << i_shamt;
            cpuPkg::ALU_SRL: o_result = i_b >> i_shamt;
            cpuPkg::ALU_SRA: o_result = $signed(i_b) >>> i_shamt;
            default:         o_result = i_b;
        endcase
    end

endmodule

// File: design/cpuPkg.sv
package cpuPkg;

    // Widths and sizes
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int MEM_ADDR_W = 6;
    localparam int MEM_WORDS  = 64;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;

    // R-type funct field
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_SRA = 6'h03;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2A;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_PASSB
    } aluOpT;

    // Coarse class from the decoder, refined by ALU control
    typedef enum logic [1:0] {
        CLS_MEMADDR, CLS_RTYPE, CLS_IMMOP
    } aluClassT;

    typedef enum logic [1:0] {
        EXT_SIGN, EXT_ZERO, EXT_UPPER
    } extModeT;

    // Operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        FWD_REGFILE, FWD_EXMEM, FWD_WB
    } fwdSelT;

endpackage

// File: design/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_instrValid,
    input  logic [cpuPkg::DATA_W-1:0]     i_instr,
    input  logic                          i_wbEn,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_wbReg,
    input  logic [cpuPkg::DATA_W-1:0]     i_wbData,
    output logic                          o_exRegWrite,
    output logic                          o_exMemRead,
    output logic                          o_exMemWrite,
    output cpuPkg::aluClassT              o_exAluClass,
    output logic                          o_exAluSrcImm,
    output logic                          o_exRegDstRd,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_exRs,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_exRt,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_exRd,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_exShamt,
    output logic [5:0]                    o_exFunct,
    output logic [5:0]                    o_exOpcode,
    output logic [cpuPkg::DATA_W-1:0]     o_exRegA,
    output logic [cpuPkg::DATA_W-1:0]     o_exRegB,
    output logic [cpuPkg::DATA_W-1:0]     o_exImm
);

    logic                          ifValid;
    logic [cpuPkg::DATA_W-1:0]     ifInstr;
    logic [cpuPkg::IMM_W-1:0]      imm;
    logic                          regWrite;
    logic                          memRead;
    logic                          memWrite;
    logic                          aluSrcImm;
    logic                          regDstRd;
    cpuPkg::aluClassT              aluClass;
    cpuPkg::extModeT               extMode;
    logic [cpuPkg::REG_ADDR_W-1:0] dest;
    logic [cpuPkg::DATA_W-1:0]     immExt;
    logic [cpuPkg::DATA_W-1:0]     rdDataA;
    logic [cpuPkg::DATA_W-1:0]     rdDataB;

    // IF/ID latch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ifValid <= 1'b0;
        end else begin
            ifValid <= i_instrValid;
        end
        ifInstr <= i_instr;
    end

    assign imm = ifInstr[cpuPkg::IMM_W-1:0];

    ////////////////////
    // Control decoder
    ////////////////////
    always_comb begin
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluSrcImm = 1'b0;
        regDstRd  = 1'b0;
        aluClass  = cpuPkg::CLS_MEMADDR;
        extMode   = cpuPkg::EXT_SIGN;
        if (ifValid) begin
            case (ifInstr[31:26])
                cpuPkg::OP_RTYPE: begin
                    regWrite = 1'b1;
                    regDstRd = 1'b1;
                    aluClass = cpuPkg::CLS_RTYPE;
                end
                cpuPkg::OP_ADDI, cpuPkg::OP_SLTI: begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluClass  = cpuPkg::CLS_IMMOP;
                end
                cpuPkg::OP_ANDI, cpuPkg::OP_ORI, cpuPkg::OP_XORI: begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluClass  = cpuPkg::CLS_IMMOP;
                    extMode   = cpuPkg::EXT_ZERO;
                end
                cpuPkg::OP_LUI: begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluClass  = cpuPkg::CLS_IMMOP;
                    extMode   = cpuPkg::EXT_UPPER;
                end
                cpuPkg::OP_LW: begin
                    regWrite  = 1'b1;
                    memRead   = 1'b1;
                    aluSrcImm = 1'b1;
                end
                cpuPkg::OP_SW: begin
                    memWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                end
                default: begin
                    regWrite = 1'b0;
                end
            endcase
        end
        // A write to r0 is a no-op from here on
        dest = regDstRd ? ifInstr[15:11] : ifInstr[20:16];
        if (dest == '0) begin
            regWrite = 1'b0;
        end
    end

    always_comb begin
        case (extMode)
            cpuPkg::EXT_ZERO:  immExt = {{(cpuPkg::DATA_W-cpuPkg::IMM_W){1'b0}}, imm};
            cpuPkg::EXT_UPPER: immExt = {imm, {(cpuPkg::DATA_W-cpuPkg::IMM_W){1'b0}}};
            default:
                immExt = {{(cpuPkg::DATA_W-cpuPkg::IMM_W){imm[cpuPkg::IMM_W-1]}}, imm};
        endcase
    end

    regFile uRegFile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wrEn    (i_wbEn),
        .i_rdAddrA (ifInstr[25:21]),
        .i_rdAddrB (ifInstr[20:16]),
        .i_wrAddr  (i_wbReg),
        .i_wrData  (i_wbData),
        .o_rdDataA (rdDataA),
        .o_rdDataB (rdDataB)
    );

    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_exRegWrite <= 1'b0;
            o_exMemRead  <= 1'b0;
            o_exMemWrite <= 1'b0;
        end else begin
            o_exRegWrite <= regWrite;
            o_exMemRead  <= memRead;
            o_exMemWrite <= memWrite;
        end
        o_exAluClass  <= aluClass;
        o_exAluSrcImm <= aluSrcImm;
        o_exRegDstRd  <= regDstRd;
        o_exRs        <= ifInstr[25:21];
        o_exRt        <= ifInstr[20:16];
        o_exRd        <= ifInstr[15:11];
        o_exShamt     <= ifInstr[10:6];
        o_exFunct     <= ifInstr[5:0];
        o_exOpcode    <= ifInstr[31:26];
        o_exRegA      <= rdDataA;
        o_exRegB      <= rdDataB;
        o_exImm       <= immExt;
    end

endmodule

// File: design/executeStage.sv
`timescale 1ns/100ps

module executeStage (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_exRegWrite,
    input  logic                          i_exMemRead,
    input  logic                          i_exMemWrite,
    input  cpuPkg::aluClassT              i_exAluClass,
    input  logic                          i_exAluSrcImm,
    input  logic                          i_exRegDstRd,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_exRs,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_exRt,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_exRd,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_exShamt,
    input  logic [5:0]                    i_exFunct,
    input  logic [5:0]                    i_exOpcode,
    input  logic [cpuPkg::DATA_W-1:0]     i_exRegA,
    input  logic [cpuPkg::DATA_W-1:0]     i_exRegB,
    input  logic [cpuPkg::DATA_W-1:0]     i_exImm,
    input  logic                          i_wbEn,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_wbReg,
    input  logic [cpuPkg::DATA_W-1:0]     i_wbData,
    output logic                          o_memRegWrite,
    output logic                          o_memRead,
    output logic                          o_memWrite,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_memDest,
    output logic [cpuPkg::DATA_W-1:0]     o_memAluResult,
    output logic [cpuPkg::DATA_W-1:0]     o_memStoreData
);

    cpuPkg::fwdSelT            fwdA;
    cpuPkg::fwdSelT            fwdB;
    logic [cpuPkg::DATA_W-1:0] opA;
    logic [cpuPkg::DATA_W-1:0] fwdRegB;
    logic [cpuPkg::DATA_W-1:0] aluResult;
    cpuPkg::aluOpT             aluOp;
    logic                      functOk;
    logic                      useA;
    logic                      useB;

    ////////////////////
    // Forwarding unit
    ////////////////////
    // Youngest producer wins, so EX/MEM is checked before writeback
    always_comb begin
        if (o_memRegWrite && o_memDest == i_exRs) begin
            fwdA = cpuPkg::FWD_EXMEM;
        end else if (i_wbEn && i_wbReg == i_exRs) begin
            fwdA = cpuPkg::FWD_WB;
        end else begin
            fwdA = cpuPkg::FWD_REGFILE;
        end
        if (o_memRegWrite && o_memDest == i_exRt) begin
            fwdB = cpuPkg::FWD_EXMEM;
        end else if (i_wbEn && i_wbReg == i_exRt) begin
            fwdB = cpuPkg::FWD_WB;
        end else begin
            fwdB = cpuPkg::FWD_REGFILE;
        end
    end

    always_comb begin
        case (fwdA)
            cpuPkg::FWD_EXMEM: opA = o_memAluResult;
            cpuPkg::FWD_WB:    opA = i_wbData;
            default:           opA = i_exRegA;
        endcase
        case (fwdB)
            cpuPkg::FWD_EXMEM: fwdRegB = o_memAluResult;
            cpuPkg::FWD_WB:    fwdRegB = i_wbData;
            default:           fwdRegB = i_exRegB;
        endcase
    end

    // ALU control
    always_comb begin
        aluOp   = cpuPkg::ALU_PASSB;
        functOk = 1'b1;
        case (i_exAluClass)
            cpuPkg::CLS_RTYPE: begin
                case (i_exFunct)
                    cpuPkg::FN_SLL: aluOp = cpuPkg::ALU_SLL;
                    cpuPkg::FN_SRL: aluOp = cpuPkg::ALU_SRL;
                    cpuPkg::FN_SRA: aluOp = cpuPkg::ALU_SRA;
                    cpuPkg::FN_ADD: aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::FN_SUB: aluOp = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND: aluOp = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:  aluOp = cpuPkg::ALU_OR;
                    cpuPkg::FN_XOR: aluOp = cpuPkg::ALU_XOR;
                    cpuPkg::FN_NOR: aluOp = cpuPkg::ALU_NOR;
                    cpuPkg::FN_SLT: aluOp = cpuPkg::ALU_SLT;
                    default:        functOk = 1'b0;
                endcase
            end
            cpuPkg::CLS_IMMOP: begin
                case (i_exOpcode)
                    cpuPkg::OP_ADDI: aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::OP_SLTI: aluOp = cpuPkg::ALU_SLT;
                    cpuPkg::OP_ANDI: aluOp = cpuPkg::ALU_AND;
                    cpuPkg::OP_ORI:  aluOp = cpuPkg::ALU_OR;
                    cpuPkg::OP_XORI: aluOp = cpuPkg::ALU_XOR;
                    default:         aluOp = cpuPkg::ALU_PASSB;
                endcase
            end
            // Loads and stores only need the address sum
            default: aluOp = cpuPkg::ALU_ADD;
        endcase
    end

    aluUnit uAlu (
        .i_op     (aluOp),
        .i_a      (opA),
        .i_b      (i_exAluSrcImm ? i_exImm : fwdRegB),
        .i_shamt  (i_exShamt),
        .o_result (aluResult)
    );

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_memRegWrite <= 1'b0;
            o_memRead     <= 1'b0;
            o_memWrite    <= 1'b0;
        end else begin
            o_memRegWrite <= i_exRegWrite && functOk;
            o_memRead     <= i_exMemRead;
            o_memWrite    <= i_exMemWrite;
        end
        o_memDest      <= i_exRegDstRd ? i_exRd : i_exRt;
        o_memAluResult <= aluResult;
        o_memStoreData <= fwdRegB;
    end

    // Operands that the instruction in EX really reads
    assign useA = ((i_exRegWrite && functOk) || i_exMemWrite) &&
                  !(aluOp inside {cpuPkg::ALU_SLL, cpuPkg::ALU_SRL,
                                  cpuPkg::ALU_SRA, cpuPkg::ALU_PASSB});
    assign useB = i_exMemWrite || (i_exRegWrite && functOk && !i_exAluSrcImm);

    // A load result is not in EX/MEM yet, so no used operand may come from there
    noLoadUseFwd: assert property (@(posedge i_clk) disable iff (i_rst)
        o_memRead |-> !(useA && fwdA == cpuPkg::FWD_EXMEM) &&
                      !(useB && fwdB == cpuPkg::FWD_EXMEM));

endmodule

// File: design/memWbStage.sv
`timescale 1ns/100ps

module memWbStage (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_memRegWrite,
    input  logic                          i_memRead,
    input  logic                          i_memWrite,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_memDest,
    input  logic [cpuPkg::DATA_W-1:0]     i_memAluResult,
    input  logic [cpuPkg::DATA_W-1:0]     i_memStoreData,
    output logic                          o_wbEn,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_wbReg,
    output logic [cpuPkg::DATA_W-1:0]     o_wbData
);

    logic [cpuPkg::DATA_W-1:0]     dataMem [cpuPkg::MEM_WORDS];
    logic [cpuPkg::MEM_ADDR_W-1:0] memIdx;
    logic                          wbRegWrite;
    logic                          wbMemToReg;
    logic [cpuPkg::REG_ADDR_W-1:0] wbDest;
    logic [cpuPkg::DATA_W-1:0]     wbAlu;
    logic [cpuPkg::DATA_W-1:0]     wbLoad;

    // Word index with the byte offset dropped
    assign memIdx = i_memAluResult[cpuPkg::MEM_ADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < cpuPkg::MEM_WORDS; i++) begin
                dataMem[i] <= '0;
            end
        end else if (i_memWrite) begin
            dataMem[memIdx] <= i_memStoreData;
        end
    end

    // MEM/WB register with the load data captured at the same edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRegWrite <= i_memRegWrite;
            wbMemToReg <= i_memRead;
        end
        wbDest <= i_memDest;
        wbAlu  <= i_memAluResult;
        wbLoad <= dataMem[memIdx];
    end

    assign o_wbEn   = wbRegWrite;
    assign o_wbReg  = wbDest;
    assign o_wbData = wbMemToReg ? wbLoad : wbAlu;

    // Decoder never sets both for one opcode
    noReadWrite: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_memRead && i_memWrite));

endmodule

// File: design/pipelineCpu.sv
`timescale 1ns/100ps

module pipelineCpu (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_instrValid,
    input  logic [cpuPkg::DATA_W-1:0]     i_instr,
    output logic                          o_wbEn,
    output logic [cpuPkg::REG_ADDR_W-1:0] o_wbReg,
    output logic [cpuPkg::DATA_W-1:0]     o_wbData
);

    // ID/EX
    logic                          exRegWrite;
    logic                          exMemRead;
    logic                          exMemWrite;
    cpuPkg::aluClassT              exAluClass;
    logic                          exAluSrcImm;
    logic                          exRegDstRd;
    logic [cpuPkg::REG_ADDR_W-1:0] exRs;
    logic [cpuPkg::REG_ADDR_W-1:0] exRt;
    logic [cpuPkg::REG_ADDR_W-1:0] exRd;
    logic [cpuPkg::REG_ADDR_W-1:0] exShamt;
    logic [5:0]                    exFunct;
    logic [5:0]                    exOpcode;
    logic [cpuPkg::DATA_W-1:0]     exRegA;
    logic [cpuPkg::DATA_W-1:0]     exRegB;
    logic [cpuPkg::DATA_W-1:0]     exImm;

    // EX/MEM
    logic                          memRegWrite;
    logic                          memRead;
    logic                          memWrite;
    logic [cpuPkg::REG_ADDR_W-1:0] memDest;
    logic [cpuPkg::DATA_W-1:0]     memAluResult;
    logic [cpuPkg::DATA_W-1:0]     memStoreData;

    ////////////////////
    // Decode
    ////////////////////
    decodeStage uDecode (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instrValid  (i_instrValid),
        .i_instr       (i_instr),
        .i_wbEn        (o_wbEn),
        .i_wbReg       (o_wbReg),
        .i_wbData      (o_wbData),
        .o_exRegWrite  (exRegWrite),
        .o_exMemRead   (exMemRead),
        .o_exMemWrite  (exMemWrite),
        .o_exAluClass  (exAluClass),
        .o_exAluSrcImm (exAluSrcImm),
        .o_exRegDstRd  (exRegDstRd),
        .o_exRs        (exRs),
        .o_exRt        (exRt),
        .o_exRd        (exRd),
        .o_exShamt     (exShamt),
        .o_exFunct     (exFunct),
        .o_exOpcode    (exOpcode),
        .o_exRegA      (exRegA),
        .o_exRegB      (exRegB),
        .o_exImm       (exImm)
    );

    ////////////////////
    // Execute
    ////////////////////
    executeStage uExecute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_exRegWrite   (exRegWrite),
        .i_exMemRead    (exMemRead),
        .i_exMemWrite   (exMemWrite),
        .i_exAluClass   (exAluClass),
        .i_exAluSrcImm  (exAluSrcImm),
        .i_exRegDstRd   (exRegDstRd),
        .i_exRs         (exRs),
        .i_exRt         (exRt),
        .i_exRd         (exRd),
        .i_exShamt      (exShamt),
        .i_exFunct      (exFunct),
        .i_exOpcode     (exOpcode),
        .i_exRegA       (exRegA),
        .i_exRegB       (exRegB),
        .i_exImm        (exImm),
        .i_wbEn         (o_wbEn),
        .i_wbReg        (o_wbReg),
        .i_wbData       (o_wbData),
        .o_memRegWrite  (memRegWrite),
        .o_memRead      (memRead),
        .o_memWrite     (memWrite),
        .o_memDest      (memDest),
        .o_memAluResult (memAluResult),
        .o_memStoreData (memStoreData)
    );

    ////////////////////
    // Memory and writeback
    ////////////////////
    memWbStage uMemWb (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_memRegWrite  (memRegWrite),
        .i_memRead      (memRead),
        .i_memWrite     (memWrite),
        .i_memDest      (memDest),
        .i_memAluResult (memAluResult),
        .i_memStoreData (memStoreData),
        .o_wbEn         (o_wbEn),
        .o_wbReg        (o_wbReg),
        .o_wbData       (o_wbData)
    );

endmodule

// File: design/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_wrEn,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_rdAddrA,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_rdAddrB,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_wrAddr,
    input  logic [cpuPkg::DATA_W-1:0]     i_wrData,
    output logic [cpuPkg::DATA_W-1:0]     o_rdDataA,
    output logic [cpuPkg::DATA_W-1:0]     o_rdDataB
);

    logic [cpuPkg::DATA_W-1:0] regs [cpuPkg::NUM_REGS];

    // Register 0 is never written, so it holds zero after reset
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEn && i_wrAddr != '0) begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

    // Write-through for an instruction decoding during writeback
    assign o_rdDataA = (i_wrEn && i_wrAddr == i_rdAddrA) ? i_wrData : regs[i_rdAddrA];
    assign o_rdDataB = (i_wrEn && i_wrAddr == i_rdAddrB) ? i_wrData : regs[i_rdAddrB];

    // Decoder drops writes to r0 long before they get here
    noZeroWrite: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wrEn |-> i_wrAddr != '0);

endmodule

// File: dv/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

    logic                          clk;
    logic                          rst;
    logic                          instrValid;
    logic [cpuPkg::DATA_W-1:0]     instr;
    logic                          wbEn;
    logic [cpuPkg::REG_ADDR_W-1:0] wbReg;
    logic [cpuPkg::DATA_W-1:0]     wbData;

    integer                        seed;
    logic [cpuPkg::DATA_W-1:0]     modelRegs [cpuPkg::NUM_REGS];
    logic [cpuPkg::DATA_W-1:0]     modelMem [cpuPkg::MEM_WORDS];
    logic [cpuPkg::REG_ADDR_W-1:0] expReg [$];
    logic [cpuPkg::DATA_W-1:0]     expData [$];
    logic [cpuPkg::REG_ADDR_W-1:0] lastLoadDest;
    int                            checkedWrites;

    pipelineCpu uut (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_instrValid (instrValid),
        .i_instr      (instr),
        .o_wbEn       (wbEn),
        .o_wbReg      (wbReg),
        .o_wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Executes one instruction in program order and queues its register write
    task automatic modelExec(input logic [31:0] ins);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] addr;
        logic [31:0] val;
        logic        wr;
        opc  = ins[31:26];
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        sh   = ins[10:6];
        fn   = ins[5:0];
        a    = modelRegs[rs];
        b    = modelRegs[rt];
        sImm = {{16{ins[15]}}, ins[15:0]};
        zImm = {16'd0, ins[15:0]};
        addr = a + sImm;
        wr   = 1'b1;
        dst  = rt;
        val  = '0;
        case (opc)
            cpuPkg::OP_RTYPE: begin
                dst = rd;
                case (fn)
                    cpuPkg::FN_SLL: val = b << sh;
                    cpuPkg::FN_SRL: val = b >> sh;
                    cpuPkg::FN_SRA: val = $signed(b) >>> sh;
                    cpuPkg::FN_ADD: val = a + b;
                    cpuPkg::FN_SUB: val = a - b;
                    cpuPkg::FN_AND: val = a & b;
                    cpuPkg::FN_OR:  val = a | b;
                    cpuPkg::FN_XOR: val = a ^ b;
                    cpuPkg::FN_NOR: val = ~(a | b);
                    cpuPkg::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:        wr = 1'b0;
                endcase
            end
            cpuPkg::OP_ADDI: val = a + sImm;
            cpuPkg::OP_SLTI: val = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            cpuPkg::OP_ANDI: val = a & zImm;
            cpuPkg::OP_ORI:  val = a | zImm;
            cpuPkg::OP_XORI: val = a ^ zImm;
            cpuPkg::OP_LUI:  val = {ins[15:0], 16'd0};
            cpuPkg::OP_LW:   val = modelMem[addr[cpuPkg::MEM_ADDR_W+1:2]];
            cpuPkg::OP_SW: begin
                wr = 1'b0;
                modelMem[addr[cpuPkg::MEM_ADDR_W+1:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            modelRegs[dst] = val;
            expReg.push_back(dst);
            expData.push_back(val);
        end
        lastLoadDest = (opc == cpuPkg::OP_LW) ? rt : '0;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    // Mostly r0..r7 so that close dependencies are common
    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = $random(seed);
        if (r[4:3] == 2'b00) begin
            return r[9:5];
        end
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic [5:0] pickFunct(input int k);
        case (k % 10)
            0:       return cpuPkg::FN_SLL;
            1:       return cpuPkg::FN_SRL;
            2:       return cpuPkg::FN_SRA;
            3:       return cpuPkg::FN_ADD;
            4:       return cpuPkg::FN_SUB;
            5:       return cpuPkg::FN_AND;
            6:       return cpuPkg::FN_OR;
            7:       return cpuPkg::FN_XOR;
            8:       return cpuPkg::FN_NOR;
            default: return cpuPkg::FN_SLT;
        endcase
    endfunction

    task automatic makeInstr(output logic [31:0] ins);
        logic [31:0] r;
        logic [3:0]  kind;
        logic [5:0]  opc;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        r    = $random(seed);
        kind = r[3:0];
        rs   = randReg();
        rt   = randReg();
        rd   = randReg();
        if (kind < 4'd5) begin
            ins = {cpuPkg::OP_RTYPE, rs, rt, rd, r[20:16], pickFunct(int'(r[31:24]))};
        end else if (kind < 4'd10) begin
            case (r[6:4])
                3'd1:    opc = cpuPkg::OP_SLTI;
                3'd2:    opc = cpuPkg::OP_ANDI;
                3'd3:    opc = cpuPkg::OP_ORI;
                3'd4:    opc = cpuPkg::OP_XORI;
                3'd5:    opc = cpuPkg::OP_LUI;
                default: opc = cpuPkg::OP_ADDI;
            endcase
            ins = {opc, rs, rt, r[31:16]};
        end else if (kind < 4'd14) begin
            // Half of the accesses use r0 as base
            opc = (kind < 4'd12) ? cpuPkg::OP_SW : cpuPkg::OP_LW;
            ins = {opc, (r[7] ? rs : 5'd0), rt, r[31:16]};
        end else if (kind == 4'd14) begin
            ins = {2'b11, r[19:16], rs, rt, r[31:16]};
        end else begin
            // Raw funct field, often undefined
            ins = {cpuPkg::OP_RTYPE, rs, rt, rd, r[20:16], r[29:24]};
        end
        // No load-use at distance 1 since nothing stalls
        if (lastLoadDest != '0) begin
            if (ins[25:21] == lastLoadDest) begin
                ins[25:21] = lastLoadDest + 5'd1;
            end
            if (ins[20:16] == lastLoadDest) begin
                ins[20:16] = lastLoadDest + 5'd1;
            end
        end
    endtask

    task automatic issue(input logic valid, input logic [31:0] ins);
        @(negedge clk);
        instrValid = valid;
        instr      = ins;
        if (valid) begin
            modelExec(ins);
        end
    endtask

    // Writeback checker
    always @(negedge clk) begin : wbMonitor
        logic [cpuPkg::REG_ADDR_W-1:0] eReg;
        logic [cpuPkg::DATA_W-1:0]     eData;
        if (wbEn === 1'b1) begin
            assert (expReg.size() != 0)
                else reportFail($sformatf("Unexpected write to r%0d at %0t", wbReg, $time));
            eReg  = expReg.pop_front();
            eData = expData.pop_front();
            assert (wbReg == eReg)
                else reportFail($sformatf("MISMATCH at %0t: o_wbReg got %0d, expected %0d",
                                          $time, wbReg, eReg));
            assert (wbData == eData)
                else reportFail($sformatf("MISMATCH at %0t: o_wbData got %h, expected %h",
                                          $time, wbData, eData));
            checkedWrites++;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] ins;
        int          waitCnt;
        seed          = 32'h6619d0e1;
        rst           = 1'b1;
        instrValid    = 1'b0;
        instr         = '0;
        lastLoadDest  = '0;
        checkedWrites = 0;
        for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < cpuPkg::MEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle pipeline with garbage on the bus and valid low
        for (int i = 0; i < 20; i++) begin
            issue(1'b0, $random(seed));
        end

        // Writes that must never retire
        issue(1'b1, {cpuPkg::OP_ADDI, 5'd0, 5'd0, 16'd5});
        issue(1'b1, {cpuPkg::OP_RTYPE, 5'd1, 5'd2, 5'd0, 5'd0, cpuPkg::FN_ADD});
        issue(1'b1, {6'h3F, 26'h155_5555});
        issue(1'b1, {cpuPkg::OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, 6'h01});

        // Short dependency chain at distances 1, 2 and 3
        issue(1'b1, {cpuPkg::OP_ADDI, 5'd0, 5'd1, 16'h8001});
        issue(1'b1, {cpuPkg::OP_ADDI, 5'd1, 5'd2, 16'd7});
        issue(1'b1, {cpuPkg::OP_ORI, 5'd1, 5'd3, 16'hF0F0});
        issue(1'b1, {cpuPkg::OP_RTYPE, 5'd1, 5'd2, 5'd4, 5'd0, cpuPkg::FN_SUB});
        issue(1'b1, {cpuPkg::OP_SW, 5'd0, 5'd4, 16'h0010});
        issue(1'b1, {cpuPkg::OP_LW, 5'd0, 5'd5, 16'h0010});
        issue(1'b1, {cpuPkg::OP_LW, 5'd0, 5'd6, 16'h0020});
        issue(1'b1, {cpuPkg::OP_RTYPE, 5'd5, 5'd3, 5'd7, 5'd0, cpuPkg::FN_XOR});

        ////////////////////
        // Random burst
        ////////////////////
        for (int i = 0; i < 600; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                issue(1'b0, $random(seed));
            end else begin
                makeInstr(ins);
                issue(1'b1, ins);
            end
        end
        issue(1'b0, '0);

        waitCnt = 0;
        while (expReg.size() != 0 && waitCnt < 100) begin
            @(posedge clk);
            waitCnt++;
        end
        // Extra pulses here are caught by the monitor
        repeat (10) @(posedge clk);

        $display("%0d register writes checked", checkedWrites);
        if (expReg.size() != 0) begin
            reportFail($sformatf("Timed out with %0d expected register writes never seen",
                                 expReg.size()));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sim.f --top-module cpuTb -o cpuTbSim \
    && ./obj_dir/cpuTbSim | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim.f
design/cpuPkg.sv
design/regFile.sv
design/aluUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/pipelineCpu.sv
dv/cpuTb.sv
